/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_avr_io
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_avr_io.sv */
module tb_avr_io;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam logic [7:0] PB_MASK = 8'hf0;
    localparam logic [7:0] PC_MASK = 8'hc0;
    localparam int TOGGLE_LIMIT = 300;
    localparam int IRQ_LIMIT    = 40;
    localparam int FLAG_RUN     = 160;   // Enough for overflow then compare at 0x80

    // Rough length of each test in cycles
    localparam int GPIO_CYCLES = 40 + 20;
    localparam int TCNT_CYCLES = 100 + 650;
    localparam int CTC_CYCLES  = 3 + 3 * TOGGLE_LIMIT;
    localparam int IRQ_CYCLES  = 2 * (FLAG_RUN + 20) + 3 * IRQ_LIMIT;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + GPIO_CYCLES + TCNT_CYCLES + CTC_CYCLES + IRQ_CYCLES + 500;

    logic       clk;
    logic       rst;
    logic [5:0] io_addr;
    logic       io_wr;
    logic       io_rd;
    logic [7:0] io_wdata;
    logic [7:0] io_rdata;
    logic [7:0] pb_in;
    logic [7:0] pc_in;
    logic [7:0] pb_out;
    logic [7:0] pb_oe;
    logic [7:0] pc_out;
    logic [7:0] pc_oe;
    logic       oc0a;
    logic       irq;
    logic [5:0] irq_vector;
    logic       irq_ack;

    int         seed;
    int         n_err;
    string      name_q[$];
    logic [7:0] exp_q[$];
    logic [7:0] act_q[$];
    string      cmp_name;
    logic [7:0] cmp_exp;
    logic [7:0] cmp_act;

    avr_io_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .io_addr    (io_addr),
        .io_wr      (io_wr),
        .io_rd      (io_rd),
        .io_wdata   (io_wdata),
        .io_rdata   (io_rdata),
        .pb_in      (pb_in),
        .pc_in      (pc_in),
        .pb_out     (pb_out),
        .pb_oe      (pb_oe),
        .pc_out     (pc_out),
        .pc_oe      (pc_oe),
        .oc0a       (oc0a),
        .irq        (irq),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [7:0] masked_reg(input logic [7:0] val, input logic [7:0] mask);
        return val & mask;
    endfunction

    function automatic logic [7:0] pin_drive(input logic [7:0] port, input logic [7:0] ddr);
        return port & ddr;   // Driven only where DDR selects output
    endfunction

    function automatic logic [7:0] tcnt_after(input logic [7:0] start, input int steps);
        int sum;
        sum = (int'(start) + steps) % 256;
        return sum[7:0];
    endfunction

    function automatic int ctc_period(input logic [7:0] top);
        return int'(top) + 1;   // 0..top inclusive
    endfunction

    // Compare A (bit 0) wins over overflow
    function automatic logic [5:0] vector_for(input logic [1:0] req);
        if (req[0])
            return avr_io_pkg::VEC_TIM0_COMPA;
        else if (req[1])
            return avr_io_pkg::VEC_TIM0_OVF;
        return 6'd0;
    endfunction

    function automatic logic [1:0] clear_served(input logic [1:0] req);
        return req & (req - 2'd1);   // Drop the lowest pending bit
    endfunction

    function automatic logic [7:0] tccr_value(input logic ctc, input avr_io_pkg::clk_sel_e cs);
        return {4'b0000, ctc, cs};
    endfunction

    task automatic push_check(input string name, input logic [7:0] exp, input logic [7:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    // Drains whatever the stimulus sampled
    always @(posedge clk)
    begin
        while (exp_q.size() > 0)
        begin
            cmp_name = name_q.pop_front();
            cmp_exp  = exp_q.pop_front();
            cmp_act  = act_q.pop_front();
            assert (cmp_act == cmp_exp)
            else
            begin
                n_err++;
                $display("[ERROR] %0t ns %s expected 0x%02h actual 0x%02h",
                         $time, cmp_name, cmp_exp, cmp_act);
                $display(">>> FAIL");
                $fatal(1, "Mismatch on %s", cmp_name);
            end
        end
    end

    // Data is written at the edge that ends the task
    task automatic write_reg(input logic [5:0] addr, input logic [7:0] data);
        io_addr  <= addr;
        io_wdata <= data;
        io_wr    <= 1'b1;
        @(posedge clk);
        io_wr <= 1'b0;
    endtask

    task automatic read_reg(input logic [5:0] addr, output logic [7:0] data);
        io_addr <= addr;
        io_rd   <= 1'b1;
        @(negedge clk);
        data = io_rdata;
        @(posedge clk);
        io_rd <= 1'b0;
    endtask

    task automatic check_reg(input string name, input logic [5:0] addr, input logic [7:0] exp);
        logic [7:0] rd;
        read_reg(addr, rd);
        push_check(name, exp, rd);
    endtask

    task automatic gpio_reg_test(input logic [5:0] port_addr, input logic [5:0] ddr_addr,
                                 input logic [7:0] mask, input logic sel_c);
        logic [31:0] rnd;
        logic [7:0]  p;
        logic [7:0]  d;
        rnd = $random(seed);
        p = rnd[7:0];
        d = rnd[15:8];
        write_reg(port_addr, p);
        write_reg(ddr_addr, d);
        check_reg(sel_c ? "PORTC" : "PORTB", port_addr, masked_reg(p, mask));
        check_reg(sel_c ? "DDRC" : "DDRB", ddr_addr, masked_reg(d, mask));
        @(negedge clk);
        push_check(sel_c ? "pc_out" : "pb_out", pin_drive(masked_reg(p, mask),
                   masked_reg(d, mask)), sel_c ? pc_out : pb_out);
        push_check(sel_c ? "pc_oe" : "pb_oe", masked_reg(d, mask), sel_c ? pc_oe : pb_oe);
        @(posedge clk);
    endtask

    task automatic toggle_gap(output int gap);
        logic last;
        int   n;
        n   = 0;
        gap = 0;
        @(negedge clk);
        last = oc0a;
        while (oc0a == last && n < TOGGLE_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        assert (n < TOGGLE_LIMIT)
        else
        begin
            $display("oc0a did not toggle within %0d cycles", TOGGLE_LIMIT);
            $display(">>> FAIL");
            $fatal(1, "No compare output toggle");
        end
        last = oc0a;
        do
        begin
            @(negedge clk);
            gap++;
        end while (oc0a == last && gap < TOGGLE_LIMIT);
        @(posedge clk);
    endtask

    task automatic wait_irq(output logic [5:0] vec);
        int n;
        n = 0;
        @(negedge clk);
        while (!irq && n < IRQ_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        assert (irq)
        else
        begin
            $display("irq did not rise within %0d cycles", IRQ_LIMIT);
            $display(">>> FAIL");
            $fatal(1, "Interrupt missing");
        end
        vec = irq_vector;
        @(posedge clk);
    endtask

    // Flag is already cleared when this returns
    task automatic ack_irq();
        irq_ack <= 1'b1;
        @(posedge clk);
        irq_ack <= 1'b0;
        @(posedge clk);
    endtask

    // Counts from 0xf0 past the wrap and up to OCR0A = 0x80
    task automatic run_to_both_flags(input logic watch_irq);
        write_reg(avr_io_pkg::TCNT0_ADDR, 8'hf0);
        write_reg(avr_io_pkg::TCCR0_ADDR, tccr_value(1'b0, avr_io_pkg::CS_DIV1));
        repeat (FLAG_RUN)
        begin
            @(negedge clk);
            if (watch_irq)
                push_check("irq", 8'h00, {7'b0, irq});
            @(posedge clk);
        end
        write_reg(avr_io_pkg::TCCR0_ADDR, tccr_value(1'b0, avr_io_pkg::CS_STOP));
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $fatal(1, "Timeout");
    end

    initial
    begin : stimulus
        logic [31:0] rnd;
        logic [7:0]  w;
        logic [7:0]  rd;
        logic [7:0]  r1;
        logic [7:0]  top;
        logic [5:0]  vec;
        int          k;
        int          gap;
        int          period;

        seed  = 32'h2f67;
        n_err = 0;
        rst      <= 1'b1;
        io_addr  <= '0;
        io_wr    <= 1'b0;
        io_rd    <= 1'b0;
        io_wdata <= '0;
        pb_in    <= '0;
        pc_in    <= '0;
        irq_ack  <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        repeat (4)
        begin
            gpio_reg_test(avr_io_pkg::PORTB_ADDR, avr_io_pkg::DDRB_ADDR, PB_MASK, 1'b0);
            gpio_reg_test(avr_io_pkg::PORTC_ADDR, avr_io_pkg::DDRC_ADDR, PC_MASK, 1'b1);
        end

        repeat (4)
        begin
            rnd = $random(seed);
            pb_in <= rnd[7:0];
            pc_in <= rnd[15:8];
            repeat (3) @(posedge clk);   // Two-flop synchroniser plus slack
            check_reg("PINB", avr_io_pkg::PINB_ADDR, masked_reg(rnd[7:0], PB_MASK));
            check_reg("PINC", avr_io_pkg::PINC_ADDR, masked_reg(rnd[15:8], PC_MASK));
        end

        write_reg(avr_io_pkg::TCCR0_ADDR, tccr_value(1'b0, avr_io_pkg::CS_DIV1));
        repeat (4)
        begin
            rnd = $random(seed);
            w   = rnd[7:0];
            k   = int'(rnd[11:8]) + 1;
            write_reg(avr_io_pkg::TCNT0_ADDR, w);
            repeat (k) @(posedge clk);
            check_reg("TCNT0", avr_io_pkg::TCNT0_ADDR, tcnt_after(w, k));
        end

        write_reg(avr_io_pkg::TCCR0_ADDR, tccr_value(1'b0, avr_io_pkg::CS_DIV64));
        read_reg(avr_io_pkg::TCNT0_ADDR, r1);
        repeat (639) @(posedge clk);   // 640 edges between the two samples
        check_reg("TCNT0 div64", avr_io_pkg::TCNT0_ADDR, tcnt_after(r1, 10));

        rnd = $random(seed);
        top = 8'd4 + {4'b0, rnd[3:0]};
        period = ctc_period(top);
        write_reg(avr_io_pkg::OCR0A_ADDR, top);
        write_reg(avr_io_pkg::TCNT0_ADDR, 8'h00);
        write_reg(avr_io_pkg::TIFR0_ADDR, 8'h03);   // Earlier counting left flags set
        write_reg(avr_io_pkg::TCCR0_ADDR, tccr_value(1'b1, avr_io_pkg::CS_DIV1));
        repeat (2)
        begin
            toggle_gap(gap);
            push_check("oc0a period", period[7:0], gap[7:0]);
        end
        read_reg(avr_io_pkg::TIFR0_ADDR, rd);
        push_check("TIFR0 compare flag", 8'h01, rd & 8'h01);

        write_reg(avr_io_pkg::TCCR0_ADDR, tccr_value(1'b0, avr_io_pkg::CS_STOP));
        write_reg(avr_io_pkg::TIFR0_ADDR, 8'h03);
        write_reg(avr_io_pkg::OCR0A_ADDR, 8'h80);
        run_to_both_flags(1'b0);
        check_reg("TIFR0", avr_io_pkg::TIFR0_ADDR, 8'h03);
        write_reg(avr_io_pkg::TIMSK0_ADDR, 8'h03);
        wait_irq(vec);
        push_check("irq_vector", {2'b00, vector_for(2'b11)}, {2'b00, vec});
        ack_irq();
        check_reg("TIFR0 after ack", avr_io_pkg::TIFR0_ADDR, {6'b0, clear_served(2'b11)});
        wait_irq(vec);
        push_check("irq_vector", {2'b00, vector_for(2'b10)}, {2'b00, vec});
        ack_irq();
        check_reg("TIFR0 after ack", avr_io_pkg::TIFR0_ADDR, {6'b0, clear_served(2'b10)});

        // Masked flags must keep irq low
        write_reg(avr_io_pkg::TIMSK0_ADDR, 8'h00);
        run_to_both_flags(1'b1);
        check_reg("TIFR0 masked", avr_io_pkg::TIFR0_ADDR, 8'h03);

        repeat (3) @(posedge clk);   // Let the compare process drain
        if (n_err == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* filelist.f */
hdl/avr_io_pkg.sv
hdl/io_bus_if.sv
hdl/gpio_port.sv
hdl/tim_prescaler.sv
hdl/tim8.sv
hdl/irq_ctrl.sv
hdl/avr_io_top.sv
dv/tb_avr_io.sv

/* hdl/avr_io_pkg.sv */
package avr_io_pkg;

    localparam int IO_ADDR_W = 6;
    localparam int DATA_W    = 8;
    localparam int VEC_W     = 6;
    localparam int IRQ_N     = 2;   // Bit 0 compare A, bit 1 overflow

    // Port B and C register map
    localparam logic [IO_ADDR_W-1:0] PINB_ADDR  = 6'h03;
    localparam logic [IO_ADDR_W-1:0] DDRB_ADDR  = 6'h04;
    localparam logic [IO_ADDR_W-1:0] PORTB_ADDR = 6'h05;
    localparam logic [IO_ADDR_W-1:0] PINC_ADDR  = 6'h06;
    localparam logic [IO_ADDR_W-1:0] DDRC_ADDR  = 6'h07;
    localparam logic [IO_ADDR_W-1:0] PORTC_ADDR = 6'h08;

    // Timer 0
    localparam logic [IO_ADDR_W-1:0] TIFR0_ADDR  = 6'h15;
    localparam logic [IO_ADDR_W-1:0] TCCR0_ADDR  = 6'h25;
    localparam logic [IO_ADDR_W-1:0] TCNT0_ADDR  = 6'h26;
    localparam logic [IO_ADDR_W-1:0] OCR0A_ADDR  = 6'h27;
    localparam logic [IO_ADDR_W-1:0] TIMSK0_ADDR = 6'h2e;

    localparam int TCCR0_CTC_BIT = 3;
    localparam int COMPA_BIT     = 0;   // Same position in TIFR0, TIMSK0 and irq lines
    localparam int OVF_BIT       = 1;

    localparam logic [VEC_W-1:0] VEC_TIM0_COMPA = 6'd21;
    localparam logic [VEC_W-1:0] VEC_TIM0_OVF   = 6'd23;

    // div8, div64, div256, div1024 from bit 0 up
    typedef logic [3:0] tick_vec_t;

    typedef enum logic [2:0] {
        CS_STOP    = 3'd0,
        CS_DIV1    = 3'd1,
        CS_DIV8    = 3'd2,
        CS_DIV64   = 3'd3,
        CS_DIV256  = 3'd4,
        CS_DIV1024 = 3'd5
    } clk_sel_e;

    typedef enum logic [1:0] {
        IRQ_IDLE  = 2'd0,
        IRQ_PEND  = 2'd1,
        IRQ_CLEAR = 2'd2
    } irq_state_e;

endpackage

/* hdl/avr_io_top.sv */
module avr_io_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [avr_io_pkg::IO_ADDR_W-1:0] io_addr,
    input  logic                             io_wr,
    input  logic                             io_rd,
    input  logic [avr_io_pkg::DATA_W-1:0]    io_wdata,
    output logic [avr_io_pkg::DATA_W-1:0]    io_rdata,
    input  logic [avr_io_pkg::DATA_W-1:0]    pb_in,
    input  logic [avr_io_pkg::DATA_W-1:0]    pc_in,
    output logic [avr_io_pkg::DATA_W-1:0]    pb_out,
    output logic [avr_io_pkg::DATA_W-1:0]    pb_oe,
    output logic [avr_io_pkg::DATA_W-1:0]    pc_out,
    output logic [avr_io_pkg::DATA_W-1:0]    pc_oe,
    output logic                             oc0a,
    output logic                             irq,
    output logic [avr_io_pkg::VEC_W-1:0]     irq_vector,
    input  logic                             irq_ack
);

    logic [avr_io_pkg::DATA_W-1:0] pb_rdata;
    logic [avr_io_pkg::DATA_W-1:0] pc_rdata;
    logic [avr_io_pkg::DATA_W-1:0] tim_rdata;
    avr_io_pkg::tick_vec_t         ticks;
    logic [avr_io_pkg::IRQ_N-1:0]  irq_req;
    logic [avr_io_pkg::IRQ_N-1:0]  irq_clr;

    io_bus_if bus ();

    assign bus.addr  = io_addr;
    assign bus.wr    = io_wr;
    assign bus.rd    = io_rd;
    assign bus.wdata = io_wdata;

    gpio_port #(
        .PIN_ADDR  (avr_io_pkg::PINB_ADDR),
        .DDR_ADDR  (avr_io_pkg::DDRB_ADDR),
        .PORT_ADDR (avr_io_pkg::PORTB_ADDR),
        .PIN_MASK  (8'hf0)                     // PB7..PB4 bonded out
    ) i_port_b (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .rdata    (pb_rdata),
        .pins_in  (pb_in),
        .pins_out (pb_out),
        .pins_oe  (pb_oe)
    );

    gpio_port #(
        .PIN_ADDR  (avr_io_pkg::PINC_ADDR),
        .DDR_ADDR  (avr_io_pkg::DDRC_ADDR),
        .PORT_ADDR (avr_io_pkg::PORTC_ADDR),
        .PIN_MASK  (8'hc0)                     // PC7 and PC6 only
    ) i_port_c (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .rdata    (pc_rdata),
        .pins_in  (pc_in),
        .pins_out (pc_out),
        .pins_oe  (pc_oe)
    );

    tim_prescaler i_prescaler (
        .clk   (clk),
        .rst   (rst),
        .ticks (ticks)
    );

    tim8 i_tim0 (
        .clk     (clk),
        .rst     (rst),
        .bus     (bus),
        .rdata   (tim_rdata),
        .ticks   (ticks),
        .irq_clr (irq_clr),
        .irq_req (irq_req),
        .oc0a    (oc0a)
    );

    irq_ctrl i_irq_ctrl (
        .clk        (clk),
        .rst        (rst),
        .irq_req    (irq_req),
        .irq_clr    (irq_clr),
        .irq        (irq),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack)
    );

    // Unaddressed peripherals drive zero, so a plain OR merges the reads
    assign io_rdata = pb_rdata | pc_rdata | tim_rdata;

endmodule

/* hdl/gpio_port.sv */
module gpio_port #(
    parameter logic [avr_io_pkg::IO_ADDR_W-1:0] PIN_ADDR  = avr_io_pkg::PINB_ADDR,
    parameter logic [avr_io_pkg::IO_ADDR_W-1:0] DDR_ADDR  = avr_io_pkg::DDRB_ADDR,
    parameter logic [avr_io_pkg::IO_ADDR_W-1:0] PORT_ADDR = avr_io_pkg::PORTB_ADDR,
    parameter logic [avr_io_pkg::DATA_W-1:0]    PIN_MASK  = 8'hff
) (
    input  logic                          clk,
    input  logic                          rst,
    io_bus_if.periph                      bus,
    output logic [avr_io_pkg::DATA_W-1:0] rdata,
    input  logic [avr_io_pkg::DATA_W-1:0] pins_in,
    output logic [avr_io_pkg::DATA_W-1:0] pins_out,
    output logic [avr_io_pkg::DATA_W-1:0] pins_oe
);

    logic [avr_io_pkg::DATA_W-1:0] port_q;
    logic [avr_io_pkg::DATA_W-1:0] ddr_q;
    logic [avr_io_pkg::DATA_W-1:0] sync_q;
    logic [avr_io_pkg::DATA_W-1:0] pin_q;
    logic                          wr_port;
    logic                          wr_ddr;

    assign wr_port = bus.wr && (bus.addr == PORT_ADDR);
    assign wr_ddr  = bus.wr && (bus.addr == DDR_ADDR);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            port_q <= '0;
            ddr_q  <= '0;
        end
        else
        begin
            if (wr_port)
                port_q <= bus.wdata & PIN_MASK; // Unbonded pins stay zero
            if (wr_ddr)
                ddr_q <= bus.wdata & PIN_MASK;
        end
    end

    // Two-flop synchroniser for the asynchronous pad inputs
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            sync_q <= '0;
            pin_q  <= '0;
        end
        else
        begin
            sync_q <= pins_in & PIN_MASK;
            pin_q  <= sync_q;
        end
    end

    assign pins_out = port_q & ddr_q;  // Only driven where the pin is an output
    assign pins_oe  = ddr_q;

    always_comb
    begin
        rdata = '0;
        if (bus.rd)
        begin
            case (bus.addr)
                PIN_ADDR:  rdata = pin_q;
                DDR_ADDR:  rdata = ddr_q;
                PORT_ADDR: rdata = port_q;
                default:   rdata = '0;
            endcase
        end
    end

endmodule

/* hdl/io_bus_if.sv */
// Single-cycle I/O register bus, write strobe plus combinational read
interface io_bus_if;

    logic [avr_io_pkg::IO_ADDR_W-1:0] addr;
    logic                             wr;
    logic                             rd;
    logic [avr_io_pkg::DATA_W-1:0]    wdata;

    // Address decode side, driven from the top-level pins
    modport master (
        output addr,
        output wr,
        output rd,
        output wdata
    );

    modport periph (
        input addr,
        input wr,
        input rd,
        input wdata
    );

endinterface

/* hdl/irq_ctrl.sv */
module irq_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [avr_io_pkg::IRQ_N-1:0]       irq_req,
    output logic [avr_io_pkg::IRQ_N-1:0]       irq_clr,
    output logic                               irq,
    output logic [avr_io_pkg::VEC_W-1:0]       irq_vector,
    input  logic                               irq_ack
);

    localparam int N = avr_io_pkg::IRQ_N;

    avr_io_pkg::irq_state_e        state_q;
    logic [N-1:0]                  sel_q;     // One-hot source being served
    logic [avr_io_pkg::VEC_W-1:0]  vec_q;
    logic [N-1:0]                  pick_oh;
    logic [avr_io_pkg::VEC_W-1:0]  pick_vec;

    // Walk down so the lowest index ends up selected
    always_comb
    begin
        pick_oh  = '0;
        pick_vec = '0;
        for (int i = N - 1; i >= 0; i--)
        begin
            if (irq_req[i])
            begin
                pick_oh    = '0;
                pick_oh[i] = 1'b1;
                if (i == avr_io_pkg::COMPA_BIT)
                    pick_vec = avr_io_pkg::VEC_TIM0_COMPA;
                else
                    pick_vec = avr_io_pkg::VEC_TIM0_OVF;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= avr_io_pkg::IRQ_IDLE;
            sel_q   <= '0;
            vec_q   <= '0;
        end
        else
        begin
            case (state_q)
                avr_io_pkg::IRQ_IDLE:
                begin
                    if (|irq_req)
                    begin
                        state_q <= avr_io_pkg::IRQ_PEND;
                        sel_q   <= pick_oh;
                        vec_q   <= pick_vec;
                    end
                end
                avr_io_pkg::IRQ_PEND:
                begin
                    if (irq_ack)
                        state_q <= avr_io_pkg::IRQ_CLEAR;
                end
                avr_io_pkg::IRQ_CLEAR:
                begin
                    state_q <= avr_io_pkg::IRQ_IDLE;  // Flag is gone by the next look
                    sel_q   <= '0;
                    vec_q   <= '0;
                end
                default: state_q <= avr_io_pkg::IRQ_IDLE;
            endcase
        end
    end

    assign irq        = (state_q == avr_io_pkg::IRQ_PEND);
    assign irq_vector = vec_q;
    assign irq_clr    = (state_q == avr_io_pkg::IRQ_CLEAR) ? sel_q : '0;

endmodule

/* hdl/tim8.sv */
module tim8 (
    input  logic                               clk,
    input  logic                               rst,
    io_bus_if.periph                           bus,
    output logic [avr_io_pkg::DATA_W-1:0]      rdata,
    input  avr_io_pkg::tick_vec_t              ticks,
    input  logic [avr_io_pkg::IRQ_N-1:0]       irq_clr,
    output logic [avr_io_pkg::IRQ_N-1:0]       irq_req,
    output logic                               oc0a
);

    localparam int W = avr_io_pkg::DATA_W;
    localparam int N = avr_io_pkg::IRQ_N;

    logic [3:0]          tccr_q;    // CTC and clock select only
    logic [W-1:0]        tcnt_q;
    logic [W-1:0]        ocr_q;
    logic [N-1:0]        timsk_q;
    logic [N-1:0]        tifr_q;
    avr_io_pkg::clk_sel_e cs;
    logic                ctc;
    logic                cnt_en;
    logic                cmp_hit;
    logic                ovf_hit;
    logic                wr_tccr;
    logic                wr_tcnt;
    logic                wr_ocr;
    logic                wr_timsk;
    logic                wr_tifr;
    logic [N-1:0]        flag_set;
    logic [N-1:0]        flag_clr;

    assign wr_tccr  = bus.wr && (bus.addr == avr_io_pkg::TCCR0_ADDR);
    assign wr_tcnt  = bus.wr && (bus.addr == avr_io_pkg::TCNT0_ADDR);
    assign wr_ocr   = bus.wr && (bus.addr == avr_io_pkg::OCR0A_ADDR);
    assign wr_timsk = bus.wr && (bus.addr == avr_io_pkg::TIMSK0_ADDR);
    assign wr_tifr  = bus.wr && (bus.addr == avr_io_pkg::TIFR0_ADDR);

    assign cs  = avr_io_pkg::clk_sel_e'(tccr_q[2:0]);
    assign ctc = tccr_q[avr_io_pkg::TCCR0_CTC_BIT];

    always_comb
    begin
        case (cs)
            avr_io_pkg::CS_DIV1:    cnt_en = 1'b1;
            avr_io_pkg::CS_DIV8:    cnt_en = ticks[0];
            avr_io_pkg::CS_DIV64:   cnt_en = ticks[1];
            avr_io_pkg::CS_DIV256:  cnt_en = ticks[2];
            avr_io_pkg::CS_DIV1024: cnt_en = ticks[3];
            default:                cnt_en = 1'b0;  // Stop, also codes 6 and 7
        endcase
    end

    // A TCNT write swallows the count step of that cycle
    assign cmp_hit = cnt_en && !wr_tcnt && (tcnt_q == ocr_q);
    assign ovf_hit = cnt_en && !wr_tcnt && !cmp_hit && !ctc && (tcnt_q == '1);

    always_comb
    begin
        flag_set                        = '0;
        flag_set[avr_io_pkg::COMPA_BIT] = cmp_hit;
        flag_set[avr_io_pkg::OVF_BIT]   = ovf_hit;
    end

    // Write one to clear, as on the real part
    assign flag_clr = irq_clr | (wr_tifr ? bus.wdata[N-1:0] : '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tccr_q  <= '0;
            ocr_q   <= '0;
            timsk_q <= '0;
            tifr_q  <= '0;
        end
        else
        begin
            if (wr_tccr)
                tccr_q <= bus.wdata[3:0];
            if (wr_ocr)
                ocr_q <= bus.wdata;
            if (wr_timsk)
                timsk_q <= bus.wdata[N-1:0];
            tifr_q <= (tifr_q & ~flag_clr) | flag_set;  // Set wins over clear
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tcnt_q <= '0;
            oc0a   <= 1'b0;
        end
        else
        begin
            if (wr_tcnt)
                tcnt_q <= bus.wdata;
            else if (cmp_hit && ctc)
                tcnt_q <= '0;
            else if (cnt_en)
                tcnt_q <= tcnt_q + 1'b1;

            if (cmp_hit)
                oc0a <= ~oc0a;   // Toggle on compare match
        end
    end

    assign irq_req = tifr_q & timsk_q;

    always_comb
    begin
        rdata = '0;
        if (bus.rd)
        begin
            case (bus.addr)
                avr_io_pkg::TCCR0_ADDR:  rdata = {{(W-4){1'b0}}, tccr_q};
                avr_io_pkg::TCNT0_ADDR:  rdata = tcnt_q;
                avr_io_pkg::OCR0A_ADDR:  rdata = ocr_q;
                avr_io_pkg::TIMSK0_ADDR: rdata = {{(W-N){1'b0}}, timsk_q};
                avr_io_pkg::TIFR0_ADDR:  rdata = {{(W-N){1'b0}}, tifr_q};
                default:                 rdata = '0;
            endcase
        end
    end

endmodule

/* hdl/tim_prescaler.sv */
module tim_prescaler (
    input  logic                  clk,
    input  logic                  rst,
    output avr_io_pkg::tick_vec_t ticks
);

    logic [9:0] cnt_q;

    always_ff @(posedge clk)
    begin
        if (rst)
            cnt_q <= '0;
        else
            cnt_q <= cnt_q + 10'd1;
    end

    // One-cycle enables, fire on the last count of each period
    always_comb
    begin
        ticks    = '0;
        ticks[0] = &cnt_q[2:0];   // div8
        ticks[1] = &cnt_q[5:0];   // div64
        ticks[2] = &cnt_q[7:0];   // div256
        ticks[3] = &cnt_q;        // div1024
    end

endmodule
